//--- list.f
source/ft2232_pkg.sv
source/ft2232_host_sequencer.sv
source/ft2232_rxf_port.sv
source/ft2232_txe_port.sv
source/ft2232_reply_checker.sv
source/ft2232_host_top.sv
sim/ft2232_host_properties.sv
sim/tb_ft2232_host.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ft2232_host -f list.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Test passed" "$log_file"; then
    echo "Simulation result: PASS"
    exit 0
fi

echo "Simulation result: FAIL"
exit 1

//--- sim/ft2232_host_properties.sv
`default_nettype none

module ft2232_host_properties (
    input logic              clk_i,
    input logic              ft2232_reset_n_i,
    input logic              fifo_oe_n_i,
    input logic              fifo_rd_n_i,
    input logic              fifo_rxf_n_o,
    input logic              fifo_txe_n_o,
    input ft2232_pkg::byte_t fifo_data_o,
    input logic              test_error_o
);

    logic read_now;

    assign read_now = !fifo_rxf_n_o && !fifo_oe_n_i && !fifo_rd_n_i;

    // Neither direction is offered while in reset
    flags_high_in_reset: assert property (
        @(posedge clk_i) !ft2232_reset_n_i |-> (fifo_rxf_n_o && fifo_txe_n_o)
    ) else $error("RXF# or TXE# low while reset is asserted");

    // Offered byte must not change until the device takes it
    data_held_until_read: assert property (
        @(posedge clk_i) disable iff (!ft2232_reset_n_i)
        (!fifo_rxf_n_o && !read_now) |=> $stable(fifo_data_o)
    ) else $error("fifo_data_o changed while RXF# was low without a read");

    error_is_sticky: assert property (
        @(posedge clk_i) disable iff (!ft2232_reset_n_i)
        test_error_o |=> test_error_o
    ) else $error("test_error_o fell without a reset");

endmodule

bind ft2232_host_top ft2232_host_properties properties_i (
    .clk_i            (clk_i),
    .ft2232_reset_n_i (ft2232_reset_n_i),
    .fifo_oe_n_i      (fifo_oe_n_i),
    .fifo_rd_n_i      (fifo_rd_n_i),
    .fifo_rxf_n_o     (fifo_rxf_n_o),
    .fifo_txe_n_o     (fifo_txe_n_o),
    .fifo_data_o      (fifo_data_o),
    .test_error_o     (test_error_o)
);

`default_nettype wire

//--- sim/tb_ft2232_host.sv
`default_nettype none

module tb_ft2232_host;

    localparam int WATCH_CYCLES  = 20;
    localparam int REPLY_PACKETS = 4;
    // Full script, short script, and the one byte read after an abort
    localparam int SCRIPT_BYTES = 2 + ft2232_pkg::PACKETS_COUNT *
                                  (ft2232_pkg::PACKET_PAYLOAD + 1) + 1 + 2 + 1;
    // Good replies at most 7 bytes per packet, corrupted packet, bad command
    localparam int REPLY_BYTES = REPLY_PACKETS * 8 + 2 +
                                 (1 + ft2232_pkg::PACKET_PAYLOAD) + 2;
    localparam int TIMEOUT_CYCLES = (SCRIPT_BYTES + REPLY_BYTES) * 8 +
                                    ft2232_pkg::STALL_CYCLES * 20 + 200;

    logic              clk_i;
    logic              ft2232_reset_n_i;
    ft2232_pkg::byte_t test_number_i;
    logic              fifo_oe_n_i;
    logic              fifo_rd_n_i;
    logic              fifo_wr_n_i;
    ft2232_pkg::byte_t fifo_data_i;
    logic              fifo_clk_o;
    logic              fifo_rxf_n_o;
    logic              fifo_txe_n_o;
    ft2232_pkg::byte_t fifo_data_o;
    logic              test_done_o;
    logic              test_error_o;
    ft2232_pkg::byte_t error_code_o;
    logic [15:0]       bytes_checked_o;

    integer            seed;
    int                errors;
    int                checks;
    int                tests_run;
    int                start_errors;
    int                cycles;
    string             test_name;
    int                rd_count;
    int                wr_count;
    int                rd_high;
    int                wr_high;
    ft2232_pkg::byte_t rd_bytes[$];
    ft2232_pkg::byte_t expected_script[$];

    ft2232_host_top dut_i (
        .clk_i            (clk_i),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .test_number_i    (test_number_i),
        .fifo_oe_n_i      (fifo_oe_n_i),
        .fifo_rd_n_i      (fifo_rd_n_i),
        .fifo_wr_n_i      (fifo_wr_n_i),
        .fifo_data_i      (fifo_data_i),
        .fifo_clk_o       (fifo_clk_o),
        .fifo_rxf_n_o     (fifo_rxf_n_o),
        .fifo_txe_n_o     (fifo_txe_n_o),
        .fifo_data_o      (fifo_data_o),
        .test_done_o      (test_done_o),
        .test_error_o     (test_error_o),
        .error_code_o     (error_code_o),
        .bytes_checked_o  (bytes_checked_o)
    );

    always #50 clk_i = ~clk_i;

    // ========================================
    // Helpers
    // ========================================
    task automatic check_value(input string label, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, label, expected, actual);
        end
    endtask

    task automatic begin_test(input string name);
        test_name    = name;
        start_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        $display("%s finished with %0d mismatches", test_name, errors - start_errors);
    endtask

    function automatic ft2232_pkg::byte_t command_byte(input ft2232_pkg::cmd_e cmd,
                                                       input int len);
        return {cmd, len[5:0]};
    endfunction

    // High cycles expected on a flag before the next transfer
    function automatic int stall_after(input int count);
        return (count % ft2232_pkg::STALL_EVERY == 0) ? ft2232_pkg::STALL_CYCLES : 0;
    endfunction

    // Host script as the sequencer should deliver it
    task automatic build_script(input ft2232_pkg::byte_t number);
        ft2232_pkg::byte_t value;
        int                p;
        int                i;
        expected_script.delete();
        value = 8'd0;
        expected_script.push_back(command_byte(ft2232_pkg::CMD_START, 1));
        expected_script.push_back(number);
        if (number == ft2232_pkg::TEST_RECEIVE || number == ft2232_pkg::TEST_RECEIVE_SEND) begin
            for (p = 0; p < ft2232_pkg::PACKETS_COUNT; p++) begin
                expected_script.push_back(command_byte(ft2232_pkg::CMD_DATA,
                                                       ft2232_pkg::PACKET_PAYLOAD));
                for (i = 0; i < ft2232_pkg::PACKET_PAYLOAD; i++) begin
                    expected_script.push_back(value);
                    value = value + 8'd1;
                end
            end
            expected_script.push_back(command_byte(ft2232_pkg::CMD_STOP, 0));
        end
    endtask

    // Ends on the edge where reset is released
    task automatic apply_reset(input ft2232_pkg::byte_t number);
        @(posedge clk_i);
        ft2232_reset_n_i <= 1'b0;
        test_number_i    <= number;
        fifo_oe_n_i      <= 1'b1;
        fifo_rd_n_i      <= 1'b1;
        fifo_wr_n_i      <= 1'b1;
        fifo_data_i      <= 8'd0;
        rd_count = 0;
        wr_count = 0;
        rd_high  = 0;
        wr_high  = 0;
        rd_bytes.delete();
        repeat (3) @(posedge clk_i);
        ft2232_reset_n_i <= 1'b1;
    endtask

    // Starts and ends on a rising edge, returns on the edge of the write
    task automatic device_write(input ft2232_pkg::byte_t value);
        int gap;
        int target;
        gap    = $random(seed) & 3;
        target = wr_count + 1;
        fifo_wr_n_i <= 1'b1;
        repeat (gap) @(posedge clk_i);
        fifo_wr_n_i <= 1'b0;
        fifo_data_i <= value;
        do begin
            @(posedge clk_i);
        end while (wr_count < target);
    endtask

    // ========================================
    // Bus monitor
    // ========================================
    // Inputs change on the rising edge, so the falling edge shows what the next edge moves
    always @(negedge clk_i) begin
        if (ft2232_reset_n_i) begin
            if (!fifo_rxf_n_o && !fifo_oe_n_i && !fifo_rd_n_i) begin
                if (rd_count > 0) begin
                    check_value("rxf stall", stall_after(rd_count), rd_high);
                end
                rd_bytes.push_back(fifo_data_o);
                rd_count++;
                rd_high = 0;
            end else if (fifo_rxf_n_o) begin
                rd_high++;
            end
            if (!fifo_txe_n_o && fifo_oe_n_i && !fifo_wr_n_i) begin
                if (wr_count > 0) begin
                    check_value("txe stall", stall_after(wr_count), wr_high);
                end
                wr_count++;
                wr_high = 0;
            end else if (fifo_txe_n_o) begin
                wr_high++;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles while in %s", cycles, test_name);
            $display("Test failed");
            $finish;
        end
    end

    // ========================================
    // Tests
    // ========================================
    task automatic run_script_test(input ft2232_pkg::byte_t number, input string name);
        int rnd;
        int i;
        int low_cycles;
        begin_test(name);
        build_script(number);
        apply_reset(number);
        while (rd_count < expected_script.size()) begin
            rnd = $random(seed);
            fifo_oe_n_i <= 1'b0;
            fifo_rd_n_i <= rnd[0];
            @(posedge clk_i);
        end
        // Keep reading so any extra byte would show up
        fifo_rd_n_i <= 1'b0;
        low_cycles = 0;
        repeat (WATCH_CYCLES) begin
            @(negedge clk_i);
            if (!fifo_rxf_n_o) begin
                low_cycles++;
            end
        end
        check_value("bytes read", expected_script.size(), rd_count);
        check_value("rxf low after script", 0, low_cycles);
        for (i = 0; i < expected_script.size() && i < rd_bytes.size(); i++) begin
            check_value($sformatf("byte %0d", i), expected_script[i], rd_bytes[i]);
        end
        end_test();
    endtask

    task automatic run_good_replies();
        int                len;
        int                p;
        int                i;
        int                count;
        ft2232_pkg::byte_t code;
        begin_test("good_replies");
        apply_reset(ft2232_pkg::TEST_SEND);
        count = 0;
        for (p = 0; p < REPLY_PACKETS; p++) begin
            len = $random(seed) & 7;
            device_write(command_byte(ft2232_pkg::CMD_DATA, len));
            for (i = 0; i < len; i++) begin
                device_write(ft2232_pkg::byte_t'(count));
                count++;
            end
        end
        code = ft2232_pkg::byte_t'($random(seed));
        device_write(command_byte(ft2232_pkg::CMD_STOPPED, 1));
        device_write(code);
        fifo_wr_n_i <= 1'b1;
        // Done follows the last reply byte by one cycle
        @(negedge clk_i);
        check_value("done early", 0, test_done_o);
        @(negedge clk_i);
        check_value("done", 1, test_done_o);
        check_value("error", 0, test_error_o);
        check_value("error code", code, error_code_o);
        check_value("bytes checked", count, bytes_checked_o);
        // Gated clock follows clk_i once reset is released
        @(posedge clk_i);
        #25;
        check_value("gated clock", 1, fifo_clk_o);
        end_test();
    endtask

    task automatic run_reset_state();
        begin_test("reset_state");
        @(posedge clk_i);
        ft2232_reset_n_i <= 1'b0;
        fifo_oe_n_i      <= 1'b1;
        fifo_rd_n_i      <= 1'b1;
        fifo_wr_n_i      <= 1'b1;
        repeat (2) @(posedge clk_i);
        // Gated clock stays low in reset even with clk_i high
        #25;
        check_value("gated clock", 0, fifo_clk_o);
        @(negedge clk_i);
        check_value("rxf", 1, fifo_rxf_n_o);
        check_value("txe", 1, fifo_txe_n_o);
        check_value("done", 0, test_done_o);
        check_value("error", 0, test_error_o);
        check_value("error code", 0, error_code_o);
        check_value("bytes checked", 0, bytes_checked_o);
        end_test();
    endtask

    task automatic run_corrupt_data();
        int                pos;
        int                i;
        int                rnd;
        ft2232_pkg::byte_t bad;
        begin_test("corrupt_data");
        apply_reset(ft2232_pkg::TEST_RECEIVE_SEND);
        pos = $random(seed) & 7;
        rnd = $random(seed);
        // Offset of 1 to 128 keeps the bad byte off the counting value
        bad = ft2232_pkg::byte_t'(pos + 1 + (rnd & 127));
        device_write(command_byte(ft2232_pkg::CMD_DATA, ft2232_pkg::PACKET_PAYLOAD));
        for (i = 0; i < pos; i++) begin
            device_write(ft2232_pkg::byte_t'(i));
        end
        device_write(bad);
        fifo_wr_n_i <= 1'b1;
        while (!test_error_o) @(negedge clk_i);
        check_value("bytes checked", pos, bytes_checked_o);
        // Only the start command is held and the script must not go on
        @(posedge clk_i);
        fifo_oe_n_i <= 1'b0;
        fifo_rd_n_i <= 1'b0;
        repeat (WATCH_CYCLES) @(negedge clk_i);
        check_value("bytes read after abort", 1, rd_count);
        check_value("rxf", 1, fifo_rxf_n_o);
        check_value("done", 0, test_done_o);
        end_test();
    endtask

    task automatic run_unknown_command();
        int rnd;
        begin_test("unknown_command");
        apply_reset(ft2232_pkg::TEST_RECEIVE_SEND);
        device_write(command_byte(ft2232_pkg::CMD_START, 1));
        fifo_wr_n_i <= 1'b1;
        while (!test_error_o) @(negedge clk_i);
        // One more write fits the register and then TXE# must stay high
        @(posedge clk_i);
        rnd = $random(seed);
        fifo_data_i <= ft2232_pkg::byte_t'(rnd);
        fifo_wr_n_i <= 1'b0;
        repeat (WATCH_CYCLES) @(negedge clk_i);
        check_value("writes accepted", 2, wr_count);
        check_value("txe", 1, fifo_txe_n_o);
        check_value("error", 1, test_error_o);
        check_value("done", 0, test_done_o);
        end_test();
    endtask

    initial begin
        clk_i            = 1'b0;
        ft2232_reset_n_i = 1'b0;
        test_number_i    = ft2232_pkg::TEST_SEND;
        fifo_oe_n_i      = 1'b1;
        fifo_rd_n_i      = 1'b1;
        fifo_wr_n_i      = 1'b1;
        fifo_data_i      = 8'd0;
        seed             = 32'hfd0d_8e34;
        errors           = 0;
        checks           = 0;
        tests_run        = 0;
        cycles           = 0;
        test_name        = "startup";

        run_script_test(ft2232_pkg::TEST_RECEIVE_SEND, "full_script");
        run_script_test(ft2232_pkg::TEST_SEND, "short_script");
        run_good_replies();
        run_reset_state();
        run_corrupt_data();
        run_unknown_command();

        $display("%0d tests run, %0d checks, %0d mismatches", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/ft2232_host_sequencer.sv
`default_nettype none

module ft2232_host_sequencer (
    input  logic              fifo_clk_o,
    input  logic              ft2232_reset_n_i,
    input  ft2232_pkg::byte_t test_number_i,
    input  logic              abort_i,
    input  logic              out_ready_i,
    output ft2232_pkg::byte_t out_data_o,
    output logic              out_valid_o
);

    typedef enum logic [2:0] {
        S_START_CMD,
        S_TEST_NUM,
        S_DATA_CMD,
        S_PAYLOAD,
        S_STOP_CMD,
        S_IDLE
    } state_e;

    state_e               state_q;
    ft2232_pkg::byte_t    pkts_left_q;
    ft2232_pkg::len_t     bytes_left_q;
    ft2232_pkg::byte_t    value_q;
    logic                 step;
    logic                 wants_data;

    assign step = out_valid_o && out_ready_i;

    // Only the receive tests get data packets and a stop command
    assign wants_data = (test_number_i == ft2232_pkg::TEST_RECEIVE) ||
                        (test_number_i == ft2232_pkg::TEST_RECEIVE_SEND);

    // Byte on offer comes straight from the state
    always_comb begin
        out_valid_o = 1'b1;
        case (state_q)
            S_START_CMD: out_data_o = {ft2232_pkg::CMD_START, ft2232_pkg::len_t'(1)};
            S_TEST_NUM:  out_data_o = test_number_i;
            S_DATA_CMD: begin
                out_data_o = {ft2232_pkg::CMD_DATA,
                              ft2232_pkg::len_t'(ft2232_pkg::PACKET_PAYLOAD)};
            end
            S_PAYLOAD:   out_data_o = value_q;
            S_STOP_CMD:  out_data_o = {ft2232_pkg::CMD_STOP, ft2232_pkg::len_t'(0)};
            default: begin
                out_data_o  = '0;
                out_valid_o = 1'b0;
            end
        endcase
    end

    always_ff @(posedge fifo_clk_o, negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            state_q      <= S_START_CMD;
            pkts_left_q  <= '0;
            bytes_left_q <= '0;
            value_q      <= '0;
        end else if (abort_i) begin
            state_q <= S_IDLE;
        end else if (step) begin
            case (state_q)
                S_START_CMD: state_q <= S_TEST_NUM;
                S_TEST_NUM: begin
                    pkts_left_q <= ft2232_pkg::byte_t'(ft2232_pkg::PACKETS_COUNT);
                    value_q     <= '0;
                    state_q     <= wants_data ? S_DATA_CMD : S_IDLE;
                end
                S_DATA_CMD: begin
                    bytes_left_q <= ft2232_pkg::len_t'(ft2232_pkg::PACKET_PAYLOAD);
                    state_q      <= S_PAYLOAD;
                end
                S_PAYLOAD: begin
                    // Payload counts on across packet boundaries
                    value_q      <= value_q + 8'd1;
                    bytes_left_q <= bytes_left_q - 1'b1;
                    if (bytes_left_q == ft2232_pkg::len_t'(1)) begin
                        pkts_left_q <= pkts_left_q - 8'd1;
                        state_q     <= (pkts_left_q == 8'd1) ? S_STOP_CMD : S_DATA_CMD;
                    end
                end
                S_STOP_CMD: state_q <= S_IDLE;
                default:    state_q <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/ft2232_host_top.sv
`default_nettype none

module ft2232_host_top (
    input  logic              clk_i,
    input  logic              ft2232_reset_n_i,
    input  ft2232_pkg::byte_t test_number_i,
    input  logic              fifo_oe_n_i,
    input  logic              fifo_rd_n_i,
    input  logic              fifo_wr_n_i,
    input  ft2232_pkg::byte_t fifo_data_i,
    output logic              fifo_clk_o,
    output logic              fifo_rxf_n_o,
    output logic              fifo_txe_n_o,
    output ft2232_pkg::byte_t fifo_data_o,
    output logic              test_done_o,
    output logic              test_error_o,
    output ft2232_pkg::byte_t error_code_o,
    output logic [15:0]       bytes_checked_o
);

    ft2232_pkg::byte_t out_data;
    logic              out_valid;
    logic              out_ready;
    ft2232_pkg::byte_t in_data;
    logic              in_valid;
    logic              in_ready;
    logic              abort;

    // Clock held low while in reset
    assign fifo_clk_o = ft2232_reset_n_i ? clk_i : 1'b0;

    // ========================================
    // Host to device
    // ========================================
    ft2232_host_sequencer sequencer_i (
        .fifo_clk_o       (fifo_clk_o),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .test_number_i    (test_number_i),
        .abort_i          (abort),
        .out_ready_i      (out_ready),
        .out_data_o       (out_data),
        .out_valid_o      (out_valid)
    );

    ft2232_rxf_port rxf_port_i (
        .fifo_clk_o       (fifo_clk_o),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .fifo_oe_n_i      (fifo_oe_n_i),
        .fifo_rd_n_i      (fifo_rd_n_i),
        .out_data_i       (out_data),
        .out_valid_i      (out_valid),
        .out_ready_o      (out_ready),
        .fifo_rxf_n_o     (fifo_rxf_n_o),
        .fifo_data_o      (fifo_data_o)
    );

    // ========================================
    // Device to host
    // ========================================
    ft2232_txe_port txe_port_i (
        .fifo_clk_o       (fifo_clk_o),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .fifo_oe_n_i      (fifo_oe_n_i),
        .fifo_wr_n_i      (fifo_wr_n_i),
        .fifo_data_i      (fifo_data_i),
        .in_ready_i       (in_ready),
        .in_data_o        (in_data),
        .in_valid_o       (in_valid),
        .fifo_txe_n_o     (fifo_txe_n_o)
    );

    ft2232_reply_checker checker_i (
        .fifo_clk_o       (fifo_clk_o),
        .ft2232_reset_n_i (ft2232_reset_n_i),
        .in_data_i        (in_data),
        .in_valid_i       (in_valid),
        .in_ready_o       (in_ready),
        .abort_o          (abort),
        .test_done_o      (test_done_o),
        .test_error_o     (test_error_o),
        .error_code_o     (error_code_o),
        .bytes_checked_o  (bytes_checked_o)
    );

endmodule

`default_nettype wire

//--- source/ft2232_pkg.sv
`default_nettype none

package ft2232_pkg;

    // ========================================
    // Data and command format
    // ========================================
    typedef logic [7:0] byte_t;

    // Command code lives in bits 7:6 of a command byte
    typedef enum logic [1:0] {
        CMD_START   = 2'd0,
        CMD_DATA    = 2'd1,
        CMD_STOP    = 2'd2,
        CMD_STOPPED = 2'd3
    } cmd_e;

    // Payload length in bits 5:0
    localparam int CMD_LEN_W = 6;
    typedef logic [CMD_LEN_W-1:0] len_t;

    // Test numbers sent after the start command
    localparam byte_t TEST_SEND         = 8'd1;
    localparam byte_t TEST_RECEIVE      = 8'd2;
    localparam byte_t TEST_RECEIVE_SEND = 8'd3;

    // Device reports success with this code
    localparam byte_t ERROR_NONE = 8'd0;

    // ========================================
    // Host script sizes
    // ========================================
    localparam int PACKETS_COUNT  = 2;
    localparam int PACKET_PAYLOAD = 8;

    // ========================================
    // Stall injection
    // ========================================
    // A port pauses after every STALL_EVERY bytes for STALL_CYCLES cycles
    localparam int STALL_EVERY  = 8;
    localparam int STALL_CYCLES = 3;

    typedef logic [$clog2(STALL_EVERY)-1:0]    xfer_cnt_t;
    typedef logic [$clog2(STALL_CYCLES+1)-1:0] stall_cnt_t;

endpackage

`default_nettype wire

//--- source/ft2232_reply_checker.sv
`default_nettype none

module ft2232_reply_checker (
    input  logic              fifo_clk_o,
    input  logic              ft2232_reset_n_i,
    input  ft2232_pkg::byte_t in_data_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    output logic              abort_o,
    output logic              test_done_o,
    output logic              test_error_o,
    output ft2232_pkg::byte_t error_code_o,
    output logic [15:0]       bytes_checked_o
);

    typedef enum logic [1:0] {
        C_CMD,
        C_DATA,
        C_STOPPED,
        C_DONE
    } state_e;

    state_e            state_q;
    ft2232_pkg::len_t  left_q;
    ft2232_pkg::byte_t expect_q;
    logic              first_q;
    logic              err_q;
    logic              take;
    ft2232_pkg::cmd_e  cmd;
    ft2232_pkg::len_t  len;

    // A failure is final, so stop taking bytes and stop the script
    assign in_ready_o   = !err_q;
    assign abort_o      = err_q;
    assign test_error_o = err_q;

    assign take = in_valid_i && in_ready_o;
    assign cmd  = ft2232_pkg::cmd_e'(in_data_i[7:6]);
    assign len  = in_data_i[ft2232_pkg::CMD_LEN_W-1:0];

    always_ff @(posedge fifo_clk_o, negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            state_q         <= C_CMD;
            left_q          <= '0;
            expect_q        <= '0;
            first_q         <= 1'b0;
            err_q           <= 1'b0;
            test_done_o     <= 1'b0;
            error_code_o    <= ft2232_pkg::ERROR_NONE;
            bytes_checked_o <= '0;
        end else if (take) begin
            case (state_q)
                // ========================================
                // Command byte
                // ========================================
                C_CMD: begin
                    left_q  <= len;
                    first_q <= 1'b1;
                    case (cmd)
                        ft2232_pkg::CMD_DATA: begin
                            // Empty DATA packet carries nothing to check
                            if (len != '0) begin
                                state_q <= C_DATA;
                            end
                        end
                        ft2232_pkg::CMD_STOPPED: begin
                            if (len == '0) begin
                                test_done_o <= 1'b1;
                                state_q     <= C_DONE;
                            end else begin
                                state_q <= C_STOPPED;
                            end
                        end
                        default: err_q <= 1'b1;
                    endcase
                end

                // ========================================
                // Payload bytes
                // ========================================
                C_DATA: begin
                    // Expected value runs on over all packets
                    if (in_data_i == expect_q) begin
                        expect_q        <= expect_q + 8'd1;
                        bytes_checked_o <= bytes_checked_o + 16'd1;
                        left_q          <= left_q - 1'b1;
                        if (left_q == ft2232_pkg::len_t'(1)) begin
                            state_q <= C_CMD;
                        end
                    end else begin
                        err_q <= 1'b1;
                    end
                end
                C_STOPPED: begin
                    if (first_q) begin
                        error_code_o <= in_data_i;
                    end
                    first_q <= 1'b0;
                    left_q  <= left_q - 1'b1;
                    if (left_q == ft2232_pkg::len_t'(1)) begin
                        test_done_o <= 1'b1;
                        state_q     <= C_DONE;
                    end
                end
                default: begin
                    // Replies after STOPPED are ignored
                    state_q <= C_DONE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/ft2232_rxf_port.sv
`default_nettype none

module ft2232_rxf_port (
    input  logic              fifo_clk_o,
    input  logic              ft2232_reset_n_i,
    input  logic              fifo_oe_n_i,
    input  logic              fifo_rd_n_i,
    input  ft2232_pkg::byte_t out_data_i,
    input  logic              out_valid_i,
    output logic              out_ready_o,
    output logic              fifo_rxf_n_o,
    output ft2232_pkg::byte_t fifo_data_o
);

    ft2232_pkg::byte_t      hold_q;
    logic                   full_q;
    ft2232_pkg::xfer_cnt_t  xfer_cnt_q;
    ft2232_pkg::stall_cnt_t stall_cnt_q;
    logic                   rd;

    // RXF# low only with a byte held and no pause running
    assign fifo_rxf_n_o = !(full_q && (stall_cnt_q == '0));
    assign fifo_data_o  = hold_q;

    // Device reads with OE# and RD# both low
    assign rd = !fifo_rxf_n_o && !fifo_oe_n_i && !fifo_rd_n_i;

    // Refill on the same edge the device takes the held byte
    assign out_ready_o = !full_q || rd;

    always_ff @(posedge fifo_clk_o) begin
        if (out_valid_i && out_ready_o) begin
            hold_q <= out_data_i;
        end
    end

    always_ff @(posedge fifo_clk_o, negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            full_q      <= 1'b0;
            xfer_cnt_q  <= '0;
            stall_cnt_q <= '0;
        end else begin
            if (out_valid_i && out_ready_o) begin
                full_q <= 1'b1;
            end else if (rd) begin
                full_q <= 1'b0;
            end

            if (stall_cnt_q != '0) begin
                stall_cnt_q <= stall_cnt_q - 1'b1;
            end

            // Pretend the FIFO ran empty every STALL_EVERY reads
            if (rd) begin
                if (xfer_cnt_q == ft2232_pkg::xfer_cnt_t'(ft2232_pkg::STALL_EVERY - 1)) begin
                    xfer_cnt_q  <= '0;
                    stall_cnt_q <= ft2232_pkg::stall_cnt_t'(ft2232_pkg::STALL_CYCLES);
                end else begin
                    xfer_cnt_q <= xfer_cnt_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/ft2232_txe_port.sv
`default_nettype none

module ft2232_txe_port (
    input  logic              fifo_clk_o,
    input  logic              ft2232_reset_n_i,
    input  logic              fifo_oe_n_i,
    input  logic              fifo_wr_n_i,
    input  ft2232_pkg::byte_t fifo_data_i,
    input  logic              in_ready_i,
    output ft2232_pkg::byte_t in_data_o,
    output logic              in_valid_o,
    output logic              fifo_txe_n_o
);

    ft2232_pkg::byte_t      data_q;
    logic                   full_q;
    logic                   armed_q;
    ft2232_pkg::xfer_cnt_t  xfer_cnt_q;
    ft2232_pkg::stall_cnt_t stall_cnt_q;
    logic                   wr;
    logic                   pop;

    assign in_data_o  = data_q;
    assign in_valid_o = full_q;
    assign pop        = full_q && in_ready_i;

    // Room when empty, or when the checker drains the register this edge.
    // armed_q keeps TXE# high for the first cycle after reset release.
    assign fifo_txe_n_o = !(armed_q && (stall_cnt_q == '0) && (!full_q || in_ready_i));

    // Device writes with OE# high and WR# low
    assign wr = !fifo_txe_n_o && fifo_oe_n_i && !fifo_wr_n_i;

    always_ff @(posedge fifo_clk_o) begin
        if (wr) begin
            data_q <= fifo_data_i;
        end
    end

    always_ff @(posedge fifo_clk_o, negedge ft2232_reset_n_i) begin
        if (!ft2232_reset_n_i) begin
            armed_q     <= 1'b0;
            full_q      <= 1'b0;
            xfer_cnt_q  <= '0;
            stall_cnt_q <= '0;
        end else begin
            armed_q <= 1'b1;

            if (wr) begin
                full_q <= 1'b1;
            end else if (pop) begin
                full_q <= 1'b0;
            end

            if (stall_cnt_q != '0) begin
                stall_cnt_q <= stall_cnt_q - 1'b1;
            end

            // Same full-FIFO pause rule as the read side
            if (wr) begin
                if (xfer_cnt_q == ft2232_pkg::xfer_cnt_t'(ft2232_pkg::STALL_EVERY - 1)) begin
                    xfer_cnt_q  <= '0;
                    stall_cnt_q <= ft2232_pkg::stall_cnt_t'(ft2232_pkg::STALL_CYCLES);
                end else begin
                    xfer_cnt_q <= xfer_cnt_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire
